// File: include/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// reorder buffer depth, power of two so indexes wrap for free
`define ROB_SIZE 16

// dispatch and retire lanes per cycle
`define ROB_WIDTH 2

// physical register file size, sets tag width
`define PHYS_REG_COUNT 64

// store queue entries, sets store index width
`define SQ_SIZE 8

`endif

// File: rob_core.f
+incdir+include
source/rob_pkg.sv
source/tag_cam.sv
source/rob_pointers.sv
source/rob_ctrl_fsm.sv
source/rob_table.sv
source/rob_top.sv
verif/rob_assert.sv
verif/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert --top-module rob_tb -f rob_core.f -o rob_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/rob_sim > sim.log 2>&1 || { echo "simulation aborted, see sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }

// File: source/rob_ctrl_fsm.sv
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_ctrl_fsm
	import rob_pkg::*;
(
	input  logic clock,
	input  logic rst_n,
	input  logic halt_retired,
	output logic running
);

	rob_state_t state_q;
	rob_state_t state_d;

	// halted is sticky, only reset brings us back
	always_comb begin
		state_d = state_q;
		case (state_q)
			ROB_RUN: begin
				if (halt_retired) begin
					state_d = ROB_HALTED;
				end
			end
			ROB_HALTED: begin
				state_d = ROB_HALTED;
			end
			default: begin
				state_d = ROB_RUN;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state_q <= ROB_RUN;
		end else begin
			state_q <= state_d;
		end
	end

	// gates dispatch and retire everywhere
	assign running = (state_q == ROB_RUN);

endmodule

// File: source/rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

	// physical register tag
	typedef logic [$clog2(`PHYS_REG_COUNT)-1:0] phys_reg_t;

	// store queue slot
	typedef logic [$clog2(`SQ_SIZE)-1:0] sq_idx_t;

	// row index, wraps modulo ROB_SIZE
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

	// occupancy or free count, one extra bit to hold ROB_SIZE itself
	typedef logic [$clog2(`ROB_SIZE):0] rob_count_t;

	// per-cycle lane count, 0 up to ROB_WIDTH
	typedef logic [$clog2(`ROB_WIDTH+1)-1:0] lane_cnt_t;

	// one buffer row, flags first then payload
	typedef struct packed {
		logic      busy;
		logic      done;
		logic      is_store;
		logic      halt;
		phys_reg_t t_old;
		phys_reg_t t_new;
		sq_idx_t   sq_idx;
	} rob_entry_t;

	typedef enum logic {ROB_RUN = 1'b0, ROB_HALTED = 1'b1} rob_state_t;

endpackage

// File: source/rob_pointers.sv
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_pointers
	import rob_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,
	input  logic       flush,
	input  logic       running,
	input  lane_cnt_t  num_dispatched,
	input  lane_cnt_t  num_retired,
	output rob_idx_t   head,
	output rob_idx_t   tail,
	output rob_count_t free_rows,
	output logic       full
);

	rob_idx_t   head_q;
	rob_idx_t   tail_q;
	rob_count_t count_q;

	// head advances by retired rows
	// tail by dispatched rows, both wrap on their own width
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else if (running) begin
			head_q  <= head_q + rob_idx_t'(num_retired);
			tail_q  <= tail_q + rob_idx_t'(num_dispatched);
			// net change, retire and dispatch in same cycle
			count_q <= count_q + rob_count_t'(num_dispatched)
				- rob_count_t'(num_retired);
		end
	end

	assign head = head_q;
	assign tail = tail_q;

	// free rows straight from registered occupancy
	assign free_rows = rob_count_t'(`ROB_SIZE) - count_q;

	// head == tail is ambiguous, so full comes from the counter
	assign full = (count_q == rob_count_t'(`ROB_SIZE));

endmodule

// File: source/rob_table.sv
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_table
	import rob_pkg::*;
(
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            flush,
	input  logic                            running,
	input  rob_idx_t                        head,
	input  rob_idx_t                        tail,
	input  rob_count_t                      free_rows,
	input  logic      [`ROB_WIDTH-1:0]      dispatch_en,
	input  phys_reg_t [`ROB_WIDTH-1:0]      dispatch_t_old,
	input  phys_reg_t [`ROB_WIDTH-1:0]      dispatch_t_new,
	input  logic      [`ROB_WIDTH-1:0]      dispatch_is_store,
	input  sq_idx_t   [`ROB_WIDTH-1:0]      dispatch_sq_idx,
	input  logic      [`ROB_WIDTH-1:0]      dispatch_halt,
	input  logic      [`ROB_SIZE-1:0]       tag_hit,
	input  logic      [`ROB_SIZE-1:0]       sq_hit,
	output logic      [`ROB_WIDTH-1:0]      dispatch_ack,
	output phys_reg_t [`ROB_SIZE-1:0]       entry_t_new,
	output sq_idx_t   [`ROB_SIZE-1:0]       entry_sq_idx,
	output lane_cnt_t                       num_dispatched,
	output lane_cnt_t                       num_retired,
	output logic                            halt_retired,
	output logic      [`ROB_WIDTH-1:0]      retire_valid,
	output phys_reg_t [`ROB_WIDTH-1:0]      retire_t_old,
	output phys_reg_t [`ROB_WIDTH-1:0]      retire_t_new,
	output logic      [`ROB_WIDTH-1:0]      retire_halt
);

	rob_entry_t [`ROB_SIZE-1:0]  rows_q;
	rob_entry_t [`ROB_SIZE-1:0]  rows_d;
	rob_idx_t   [`ROB_WIDTH-1:0] dispatch_slot;
	rob_idx_t   [`ROB_WIDTH-1:0] retire_slot;

	// dispatch lanes in order, a refused lane blocks the ones behind it
	always_comb begin
		rob_count_t room;
		rob_idx_t   slot;
		logic       chain;
		room = free_rows;
		slot = tail;
		chain = running & ~flush;
		num_dispatched = '0;
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			dispatch_ack[l] = chain & dispatch_en[l] & (room != '0);
			dispatch_slot[l] = slot;
			if (dispatch_en[l] && !dispatch_ack[l]) begin
				chain = 1'b0;
			end
			// packed slots, an idle lane takes no row
			if (dispatch_ack[l]) begin
				room = room - rob_count_t'(1);
				slot = slot + rob_idx_t'(1);
				num_dispatched = num_dispatched + lane_cnt_t'(1);
			end
		end
	end

	// tags seen by the cams, incoming rows show their dispatch tags
	// so a same-cycle broadcast still lands
	always_comb begin
		for (int i = 0; i < `ROB_SIZE; i++) begin
			entry_t_new[i] = rows_q[i].t_new;
			entry_sq_idx[i] = rows_q[i].sq_idx;
		end
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			if (dispatch_ack[l]) begin
				entry_t_new[dispatch_slot[l]] = dispatch_t_new[l];
				entry_sq_idx[dispatch_slot[l]] = dispatch_sq_idx[l];
			end
		end
	end

	// retire from head, registered state only
	always_comb begin
		logic chain;
		chain = running & ~flush;
		num_retired = '0;
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			retire_slot[l] = head + rob_idx_t'(l);
			retire_valid[l] = chain & rows_q[retire_slot[l]].busy
				& rows_q[retire_slot[l]].done;
			retire_t_old[l] = rows_q[retire_slot[l]].t_old;
			retire_t_new[l] = rows_q[retire_slot[l]].t_new;
			retire_halt[l] = retire_valid[l] & rows_q[retire_slot[l]].halt;
			// nothing retires behind a halt
			chain = retire_valid[l] & ~rows_q[retire_slot[l]].halt;
			if (retire_valid[l]) begin
				num_retired = num_retired + lane_cnt_t'(1);
			end
		end
	end

	assign halt_retired = |retire_halt;

	// next row state: completion, then retire, then dispatch
	always_comb begin
		rows_d = rows_q;
		for (int i = 0; i < `ROB_SIZE; i++) begin
			// stores finish on the sq index, everything else on the tag
			if (rows_q[i].busy) begin
				rows_d[i].done = rows_q[i].done
					| (rows_q[i].is_store ? sq_hit[i] : tag_hit[i]);
			end
		end
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			if (retire_valid[l]) begin
				rows_d[retire_slot[l]].busy = 1'b0;
				rows_d[retire_slot[l]].done = 1'b0;
			end
		end
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			if (dispatch_ack[l]) begin
				rows_d[dispatch_slot[l]].busy = 1'b1;
				rows_d[dispatch_slot[l]].done = dispatch_is_store[l]
					? sq_hit[dispatch_slot[l]] : tag_hit[dispatch_slot[l]];
				rows_d[dispatch_slot[l]].is_store = dispatch_is_store[l];
				rows_d[dispatch_slot[l]].halt = dispatch_halt[l];
				rows_d[dispatch_slot[l]].t_old = dispatch_t_old[l];
				rows_d[dispatch_slot[l]].t_new = dispatch_t_new[l];
				rows_d[dispatch_slot[l]].sq_idx = dispatch_sq_idx[l];
			end
		end
	end

	// flush drops every row in one clock, payload left as is
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			for (int i = 0; i < `ROB_SIZE; i++) begin
				rows_q[i].busy <= 1'b0;
				rows_q[i].done <= 1'b0;
			end
		end else begin
			rows_q <= rows_d;
		end
	end

endmodule

// File: source/rob_top.sv
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_top
	import rob_pkg::*;
(
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic      [`ROB_WIDTH-1:0] dispatch_en,
	input  phys_reg_t [`ROB_WIDTH-1:0] dispatch_t_old,
	input  phys_reg_t [`ROB_WIDTH-1:0] dispatch_t_new,
	input  logic      [`ROB_WIDTH-1:0] dispatch_is_store,
	input  sq_idx_t   [`ROB_WIDTH-1:0] dispatch_sq_idx,
	input  logic      [`ROB_WIDTH-1:0] dispatch_halt,
	input  logic      [`ROB_WIDTH-1:0] cdb_en,
	input  phys_reg_t [`ROB_WIDTH-1:0] cdb_tag,
	input  logic                       sq_done,
	input  sq_idx_t                    sq_done_idx,
	input  logic                       flush,
	output logic      [`ROB_WIDTH-1:0] dispatch_ack,
	output logic      [`ROB_WIDTH-1:0] retire_valid,
	output phys_reg_t [`ROB_WIDTH-1:0] retire_t_old,
	output phys_reg_t [`ROB_WIDTH-1:0] retire_t_new,
	output logic      [`ROB_WIDTH-1:0] retire_halt,
	output rob_count_t                 free_rows,
	output logic                       full,
	output logic                       halted
);

	rob_idx_t                       head;
	rob_idx_t                       tail;
	lane_cnt_t                      num_dispatched;
	lane_cnt_t                      num_retired;
	logic                           halt_retired;
	logic                           running;
	logic      [`ROB_SIZE-1:0]      tag_hit;
	logic      [`ROB_SIZE-1:0]      sq_hit;
	phys_reg_t [`ROB_SIZE-1:0]      entry_t_new;
	sq_idx_t   [`ROB_SIZE-1:0]      entry_sq_idx;

	rob_table table_i (
		.clock, .rst_n, .flush, .running, .head, .tail, .free_rows,
		.dispatch_en, .dispatch_t_old, .dispatch_t_new, .dispatch_is_store,
		.dispatch_sq_idx, .dispatch_halt, .tag_hit, .sq_hit, .dispatch_ack,
		.entry_t_new, .entry_sq_idx, .num_dispatched, .num_retired,
		.halt_retired, .retire_valid, .retire_t_old, .retire_t_new, .retire_halt
	);

	// result bus against every row's destination tag
	tag_cam #(.tag_t(phys_reg_t), .N_PROBE(`ROB_WIDTH), .N_ENTRY(`ROB_SIZE)) reg_cam (
		.probe_en(cdb_en), .probe_tag(cdb_tag), .entry_tag(entry_t_new), .hit(tag_hit)
	);

	// single store-done port against every row's sq slot
	tag_cam #(.tag_t(sq_idx_t), .N_PROBE(1), .N_ENTRY(`ROB_SIZE)) sq_cam (
		.probe_en(sq_done), .probe_tag(sq_done_idx), .entry_tag(entry_sq_idx), .hit(sq_hit)
	);

	rob_pointers pointers_i (
		.clock, .rst_n, .flush, .running, .num_dispatched, .num_retired,
		.head, .tail, .free_rows, .full
	);

	rob_ctrl_fsm ctrl_i (.clock, .rst_n, .halt_retired, .running);

	assign halted = ~running;

endmodule

// File: source/tag_cam.sv
`timescale 1ns/10ps
`include "rob_params.svh"

module tag_cam
	import rob_pkg::*;
#(
	parameter type tag_t = phys_reg_t,
	parameter int N_PROBE = `ROB_WIDTH,
	parameter int N_ENTRY = `ROB_SIZE
) (
	input  logic [N_PROBE-1:0] probe_en,
	input  tag_t [N_PROBE-1:0] probe_tag,
	input  tag_t [N_ENTRY-1:0] entry_tag,
	output logic [N_ENTRY-1:0] hit
);

	// full cross compare, every probe against every row
	always_comb begin
		hit = '0;
		for (int e = 0; e < N_ENTRY; e++) begin
			for (int p = 0; p < N_PROBE; p++) begin
				// disabled probes never match, even on a stale tag
				if (probe_en[p] && (probe_tag[p] == entry_tag[e])) begin
					hit[e] = 1'b1;
				end
			end
		end
	end

	// the caller decides which rows may use the hit
	// e.g. only busy rows, only stores

endmodule

// File: verif/rob_assert.sv
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_assert
	import rob_pkg::*;
(
	input logic                  clock,
	input logic                  rst_n,
	input logic [`ROB_WIDTH-1:0] dispatch_ack,
	input logic [`ROB_WIDTH-1:0] retire_valid,
	input logic [`ROB_WIDTH-1:0] retire_halt,
	input rob_count_t            free_rows,
	input logic                  full,
	input logic                  halted
);

	// a full buffer accepts nothing
	full_blocks_dispatch: assert property (@(posedge clock) disable iff (!rst_n)
		full |-> (dispatch_ack == '0))
		else $error("dispatch_ack high while full");

	free_in_range: assert property (@(posedge clock) disable iff (!rst_n)
		free_rows <= rob_count_t'(`ROB_SIZE))
		else $error("free_rows above buffer depth");

	// a halted buffer retires nothing
	no_retire_halted: assert property (@(posedge clock) disable iff (!rst_n)
		!(halted && (|retire_valid)))
		else $error("retire_valid high while halted");

	// retired halt stops the buffer from the next cycle on
	halt_stops_buffer: assert property (@(posedge clock) disable iff (!rst_n)
		(|retire_halt) |=> halted)
		else $error("halted not set after a halt retired");

endmodule

bind rob_top rob_assert rob_assert_i (
	.clock, .rst_n, .dispatch_ack, .retire_valid, .retire_halt, .free_rows, .full, .halted
);

// File: verif/rob_tb.sv
`timescale 1ns/10ps
`include "rob_params.svh"

module rob_tb
	import rob_pkg::*;
();

	localparam int PHASE_CYCLES = 400;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_PHASES = 6;
	localparam int PERIOD_NS = 4;

	logic                       clock;
	logic                       rst_n;
	logic      [`ROB_WIDTH-1:0] dispatch_en;
	phys_reg_t [`ROB_WIDTH-1:0] dispatch_t_old;
	phys_reg_t [`ROB_WIDTH-1:0] dispatch_t_new;
	logic      [`ROB_WIDTH-1:0] dispatch_is_store;
	sq_idx_t   [`ROB_WIDTH-1:0] dispatch_sq_idx;
	logic      [`ROB_WIDTH-1:0] dispatch_halt;
	logic      [`ROB_WIDTH-1:0] cdb_en;
	phys_reg_t [`ROB_WIDTH-1:0] cdb_tag;
	logic                       sq_done;
	sq_idx_t                    sq_done_idx;
	logic                       flush;
	logic      [`ROB_WIDTH-1:0] dispatch_ack;
	logic      [`ROB_WIDTH-1:0] retire_valid;
	phys_reg_t [`ROB_WIDTH-1:0] retire_t_old;
	phys_reg_t [`ROB_WIDTH-1:0] retire_t_new;
	logic      [`ROB_WIDTH-1:0] retire_halt;
	rob_count_t                 free_rows;
	logic                       full;
	logic                       halted;

	// reference model: buffer contents in order, oldest first
	rob_entry_t model_q[$];
	logic       model_halted;
	// tags and sq slots held by live entries
	logic       tag_live[`PHYS_REG_COUNT];
	logic       sq_live[`SQ_SIZE];
	int         errors;

	rob_top rob_top_i (.*);

	always #(PERIOD_NS / 2) clock = ~clock;

	task automatic check_tag(input string name, input phys_reg_t exp, input phys_reg_t act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input rob_count_t exp, input rob_count_t act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %0b, actual %0b", name, exp, act);
			errors++;
		end
	endtask

	task automatic idle_inputs();
		dispatch_en = '0;
		dispatch_t_old = '0;
		dispatch_t_new = '0;
		dispatch_is_store = '0;
		dispatch_sq_idx = '0;
		dispatch_halt = '0;
		cdb_en = '0;
		cdb_tag = '0;
		sq_done = 1'b0;
		sq_done_idx = '0;
		flush = 1'b0;
	endtask

	// any tag no live entry holds, and not the other lane's
	function automatic phys_reg_t free_tag(input int avoid);
		phys_reg_t t;
		t = phys_reg_t'($urandom);
		while (tag_live[t] || int'(t) == avoid) begin
			t = phys_reg_t'(t + 1);
		end
		return t;
	endfunction

	// -1 when every sq slot is taken
	function automatic int pick_sq(input int avoid);
		int start;
		int s;
		start = int'($urandom % `SQ_SIZE);
		for (int k = 0; k < `SQ_SIZE; k++) begin
			s = (start + k) % `SQ_SIZE;
			if (!sq_live[s] && s != avoid) begin
				return s;
			end
		end
		return -1;
	endfunction

	task automatic reset_dut(input string name);
		@(posedge clock);
		#1;
		rst_n = 1'b0;
		idle_inputs();
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rst_n = 1'b1;
		model_q.delete();
		model_halted = 1'b0;
		foreach (tag_live[i]) tag_live[i] = 1'b0;
		foreach (sq_live[i]) sq_live[i] = 1'b0;
		#1;
		// outputs straight out of reset
		check_flag({name, " reset retire_valid"}, 1'b0, |retire_valid);
		check_flag({name, " reset dispatch_ack"}, 1'b0, |dispatch_ack);
		check_flag({name, " reset halted"}, 1'b0, halted);
		check_flag({name, " reset full"}, 1'b0, full);
		check_count({name, " reset free_rows"}, rob_count_t'(`ROB_SIZE), free_rows);
	endtask

	// percentages for dispatch, broadcast, store; per mille for flush and halt
	task automatic drive_cycle(input int disp_pct, input int cdb_pct, input int st_pct,
		input int fl_pm, input int halt_pm);
		int sq;
		int pick;
		int avoid_sq;
		avoid_sq = -1;
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			dispatch_en[l] = int'($urandom % 100) < disp_pct;
			dispatch_t_old[l] = phys_reg_t'($urandom);
			dispatch_t_new[l] = free_tag(l == 0 ? -1 : int'(dispatch_t_new[0]));
			sq = pick_sq(avoid_sq);
			dispatch_is_store[l] = (sq >= 0) && (int'($urandom % 100) < st_pct);
			dispatch_sq_idx[l] = sq_idx_t'(sq >= 0 ? sq : 0);
			if (dispatch_is_store[l]) begin
				avoid_sq = sq;
			end
			dispatch_halt[l] = int'($urandom % 1000) < halt_pm;
		end
		// broadcast live tags, stores' too, or a tag dispatched this cycle
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			cdb_en[l] = int'($urandom % 100) < cdb_pct;
			pick = int'($urandom % (model_q.size() + 2));
			if (pick < model_q.size()) begin
				cdb_tag[l] = model_q[pick].t_new;
			end else begin
				cdb_tag[l] = dispatch_t_new[pick - model_q.size()];
			end
		end
		sq_done = int'($urandom % 100) < cdb_pct;
		sq_done_idx = sq_idx_t'($urandom);
		pick = int'($urandom % (model_q.size() + 1));
		if (pick < model_q.size() && model_q[pick].is_store) begin
			sq_done_idx = model_q[pick].sq_idx;
		end
		flush = int'($urandom % 1000) < fl_pm;
	endtask

	task automatic check_and_step(input string name);
		int         n_ret;
		rob_count_t room;
		logic       chain;
		logic       exp_ret;
		logic       exp_ack;
		rob_entry_t e;
		rob_entry_t new_q[$];
		check_count({name, " free_rows"}, rob_count_t'(`ROB_SIZE - model_q.size()), free_rows);
		check_flag({name, " full"}, model_q.size() == `ROB_SIZE, full);
		check_flag({name, " halted"}, model_halted, halted);
		// retire lanes, only done flags from earlier cycles count
		chain = !model_halted && !flush;
		n_ret = 0;
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			exp_ret = chain && (model_q.size() > l) && model_q[l].done;
			check_flag($sformatf("%s retire_valid[%0d]", name, l), exp_ret, retire_valid[l]);
			if (exp_ret) begin
				check_tag($sformatf("%s retire_t_old[%0d]", name, l), model_q[l].t_old,
					retire_t_old[l]);
				check_tag($sformatf("%s retire_t_new[%0d]", name, l), model_q[l].t_new,
					retire_t_new[l]);
				check_flag($sformatf("%s retire_halt[%0d]", name, l), model_q[l].halt,
					retire_halt[l]);
				n_ret++;
				chain = !model_q[l].halt;
			end else begin
				chain = 1'b0;
			end
		end
		// dispatch lanes in order against the free count
		room = rob_count_t'(`ROB_SIZE - model_q.size());
		chain = !model_halted && !flush;
		for (int l = 0; l < `ROB_WIDTH; l++) begin
			exp_ack = chain && dispatch_en[l] && (room != '0);
			check_flag($sformatf("%s dispatch_ack[%0d]", name, l), exp_ack, dispatch_ack[l]);
			if (dispatch_en[l] && !exp_ack) begin
				chain = 1'b0;
			end
			if (exp_ack) begin
				room = room - rob_count_t'(1);
				e.busy = 1'b1;
				e.done = 1'b0;
				e.is_store = dispatch_is_store[l];
				e.halt = dispatch_halt[l];
				e.t_old = dispatch_t_old[l];
				e.t_new = dispatch_t_new[l];
				e.sq_idx = dispatch_sq_idx[l];
				new_q.push_back(e);
			end
		end
		// state at the edge
		if (flush) begin
			model_q.delete();
			foreach (tag_live[i]) tag_live[i] = 1'b0;
			foreach (sq_live[i]) sq_live[i] = 1'b0;
			return;
		end
		repeat (n_ret) begin
			e = model_q.pop_front();
			tag_live[e.t_new] = 1'b0;
			if (e.is_store) begin
				sq_live[e.sq_idx] = 1'b0;
			end
			if (e.halt) begin
				model_halted = 1'b1;
			end
		end
		foreach (new_q[i]) begin
			model_q.push_back(new_q[i]);
			tag_live[new_q[i].t_new] = 1'b1;
			if (new_q[i].is_store) begin
				sq_live[new_q[i].sq_idx] = 1'b1;
			end
		end
		// completion, stores by sq slot only, the rest by result tag
		for (int i = 0; i < model_q.size(); i++) begin
			e = model_q[i];
			if (e.is_store) begin
				if (sq_done && sq_done_idx == e.sq_idx) begin
					e.done = 1'b1;
				end
			end else begin
				for (int l = 0; l < `ROB_WIDTH; l++) begin
					if (cdb_en[l] && cdb_tag[l] == e.t_new) begin
						e.done = 1'b1;
					end
				end
			end
			model_q[i] = e;
		end
	endtask

	task automatic run_phase(input string name, input int disp_pct, input int cdb_pct,
		input int st_pct, input int fl_pm, input int halt_pm);
		reset_dut(name);
		for (int c = 0; c < PHASE_CYCLES; c++) begin
			@(posedge clock);
			#1;
			drive_cycle(disp_pct, cdb_pct, st_pct, fl_pm, halt_pm);
			#1;
			check_and_step(name);
		end
	endtask

	// watchdog, all phases with their resets, twice over
	initial begin
		#(NUM_PHASES * (RESET_CYCLES + PHASE_CYCLES + 2) * PERIOD_NS * 2);
		$display("timeout: the run did not finish in the expected time");
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h6a12));
		errors = 0;
		clock = 1'b0;
		rst_n = 1'b0;
		model_halted = 1'b0;
		idle_inputs();
		run_phase("ooo_retire", 60, 50, 0, 0, 0);
		// low broadcast rate so the buffer fills
		run_phase("two_wide_full", 95, 15, 10, 0, 0);
		run_phase("store_complete", 70, 60, 60, 0, 0);
		run_phase("flush", 80, 40, 30, 30, 0);
		run_phase("halt", 70, 50, 20, 0, 8);
		run_phase("mixed", 75, 45, 30, 10, 3);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
